// ==== include/spi_bridge_cfg.svh ====
//////////////////////////////
// Widths, opcodes and SFR limits for the SPI register bridge.
// The frame format fixes one nibble and one byte of address.
//////////////////////////////
`ifndef SPI_BRIDGE_CFG_SVH
`define SPI_BRIDGE_CFG_SVH

`define SB_ADDR_W     12
`define SB_SFR_W      16
`define SB_WORD_W     32

`define SB_SFR_COUNT  64
`define SB_SFR_ID     16'hB51D

`define SB_OP_RD_SFR  4'h0
`define SB_OP_WR_SFR  4'h1
`define SB_OP_RD_WORD 4'h2
`define SB_OP_WR_WORD 4'h3

`endif

// ==== logic/spi_bridge_pkg.sv ====
//////////////////////////////
// Shared types for the SPI register bridge.
//////////////////////////////
`include "spi_bridge_cfg.svh"

package spi_bridge_pkg;

    typedef logic [7:0]              byte_t;
    typedef logic [`SB_ADDR_W-1:0]   addr_t;
    typedef logic [`SB_SFR_W-1:0]    sfr_data_t;
    typedef logic [`SB_WORD_W-1:0]   word_t;
    typedef logic [3:0]              opcode_t;

    // one state per byte still expected in the current frame.
    typedef enum logic [4:0] {
        ST_DISCARD,
        ST_RD_SFR_ADDR,
        ST_RD_SFR_B0,
        ST_RD_SFR_B1,
        ST_WR_SFR_ADDR,
        ST_WR_SFR_B0,
        ST_WR_SFR_B1,
        ST_RD_WORD_ADDR,
        ST_RD_WORD_B0,
        ST_RD_WORD_B1,
        ST_RD_WORD_B2,
        ST_RD_WORD_B3,
        ST_WR_WORD_ADDR,
        ST_WR_WORD_B0,
        ST_WR_WORD_B1,
        ST_WR_WORD_B2,
        ST_WR_WORD_B3
    } ctrl_state_t;

endpackage

// ==== logic/spi_byte_slave.sv ====
//////////////////////////////
// SPI mode 0 byte slave with CS_N active low.
// SCLK half period must be at least 4 clk cycles.
//////////////////////////////
`timescale 1ns/1ps

module spi_byte_slave
    import spi_bridge_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  sclk,
    input  logic  cs_n,
    input  logic  mosi,
    output logic  miso,
    output byte_t rx_byte,
    output logic  rx_valid,
    output logic  rx_first,
    output logic  frame_end,
    output logic  tx_load,
    input  byte_t tx_byte
);

    logic       sclk_meta;
    logic       sclk_sync;
    logic       sclk_prev;
    logic       cs_meta;
    logic       cs_sync;
    logic       cs_prev;
    logic       mosi_meta;
    logic       mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_fall;
    logic       cs_rise;
    logic       cs_active;
    logic [2:0] bit_cnt;
    logic [6:0] rx_sr;
    logic       first_pend;
    byte_t      tx_sr;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            cs_meta   <= 1'b1;   // bus idle, so no edge is seen out of reset.
            cs_sync   <= 1'b1;
            cs_prev   <= 1'b1;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            cs_meta   <= cs_n;
            cs_sync   <= cs_meta;
            cs_prev   <= cs_sync;
        end
    end

    always_ff @(posedge clk) begin
        mosi_meta <= mosi;
        mosi_sync <= mosi_meta;  // same depth as sclk, so data lines up with its edge.
    end

    assign sclk_rise = sclk_sync & ~sclk_prev;
    assign sclk_fall = ~sclk_sync & sclk_prev;
    assign cs_fall   = ~cs_sync & cs_prev;
    assign cs_rise   = cs_sync & ~cs_prev;
    assign cs_active = ~cs_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= 3'd0;
            rx_valid   <= 1'b0;
            rx_first   <= 1'b0;
            first_pend <= 1'b0;
            frame_end  <= 1'b0;
            tx_load    <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;
            frame_end <= cs_rise;
            tx_load   <= rx_valid;
            if (cs_fall) begin
                first_pend <= 1'b1;
            end
            if (!cs_active) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid   <= 1'b1;
                    rx_first   <= first_pend;
                    first_pend <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            rx_sr <= {rx_sr[5:0], mosi_sync};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {rx_sr, mosi_sync};
            end
        end
    end

    // the first falling edge after a load puts the reply msb on the pin.
    always_ff @(posedge clk) begin
        if (rst || !cs_active) begin
            miso  <= 1'b0;
            tx_sr <= 8'h00;
        end else if (tx_load) begin
            tx_sr <= tx_byte;
        end else if (sclk_fall) begin
            miso  <= tx_sr[7];
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
    end

endmodule

// ==== logic/spi_cmd_ctrl.sv ====
//////////////////////////////
// Frame decoder for the SPI register bridge.
// Unknown opcodes and surplus bytes are dropped until CS_N rises.
// Read data must arrive one clk after the read strobe.
//////////////////////////////
`timescale 1ns/1ps
`include "spi_bridge_cfg.svh"

module spi_cmd_ctrl
    import spi_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  byte_t     rx_byte,
    input  logic      rx_valid,
    input  logic      rx_first,
    input  logic      frame_end,
    input  logic      tx_load,
    output byte_t     tx_byte,
    output addr_t     sfr_addr,
    output sfr_data_t sfr_wdata,
    output logic      sfr_wr,
    output logic      sfr_rd,
    input  sfr_data_t sfr_rdata,
    output addr_t     word_addr,
    output word_t     word_wdata,
    output logic      word_wr,
    output logic      word_rd,
    input  word_t     word_rdata
);

    ctrl_state_t                state;
    ctrl_state_t                state_next;
    opcode_t                    op;
    logic [`SB_ADDR_W-9:0]      addr_hi;
    byte_t                      addr_lo;
    byte_t                      data0;
    byte_t                      data1;
    byte_t                      data2;
    word_t                      reply;
    word_t                      fresh;
    word_t                      cur_reply;
    addr_t                      acc_addr;
    logic                       rd_pend;
    logic                       byte_in;
    logic                       rd_addr_byte;

    assign op      = opcode_t'(rx_byte[7:4]);
    assign byte_in = rx_valid & ~rx_first;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_DISCARD;
            rd_pend <= 1'b0;
        end else begin
            state   <= state_next;
            rd_pend <= sfr_rd | word_rd;
        end
    end

    always_comb begin
        state_next = state;
        if (frame_end) begin
            state_next = ST_DISCARD;
        end else if (rx_valid && rx_first) begin
            case (op)
                `SB_OP_RD_SFR:  state_next = ST_RD_SFR_ADDR;
                `SB_OP_WR_SFR:  state_next = ST_WR_SFR_ADDR;
                `SB_OP_RD_WORD: state_next = ST_RD_WORD_ADDR;
                `SB_OP_WR_WORD: state_next = ST_WR_WORD_ADDR;
                default:        state_next = ST_DISCARD;
            endcase
        end else if (rx_valid) begin
            case (state)
                ST_RD_SFR_ADDR:  state_next = ST_RD_SFR_B0;
                ST_RD_SFR_B0:    state_next = ST_RD_SFR_B1;
                ST_WR_SFR_ADDR:  state_next = ST_WR_SFR_B0;
                ST_WR_SFR_B0:    state_next = ST_WR_SFR_B1;
                ST_RD_WORD_ADDR: state_next = ST_RD_WORD_B0;
                ST_RD_WORD_B0:   state_next = ST_RD_WORD_B1;
                ST_RD_WORD_B1:   state_next = ST_RD_WORD_B2;
                ST_RD_WORD_B2:   state_next = ST_RD_WORD_B3;
                ST_WR_WORD_ADDR: state_next = ST_WR_WORD_B0;
                ST_WR_WORD_B0:   state_next = ST_WR_WORD_B1;
                ST_WR_WORD_B1:   state_next = ST_WR_WORD_B2;
                ST_WR_WORD_B2:   state_next = ST_WR_WORD_B3;
                default:         state_next = ST_DISCARD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && rx_first) begin
            addr_hi <= rx_byte[`SB_ADDR_W-9:0];
        end
        if (byte_in && (state == ST_WR_SFR_ADDR || state == ST_WR_WORD_ADDR)) begin
            addr_lo <= rx_byte;
        end
        if (byte_in && (state == ST_WR_SFR_B0 || state == ST_WR_WORD_B0)) begin
            data0 <= rx_byte;
        end
        if (byte_in && state == ST_WR_WORD_B1) begin
            data1 <= rx_byte;
        end
        if (byte_in && state == ST_WR_WORD_B2) begin
            data2 <= rx_byte;
        end
        if (tx_load && rd_pend) begin
            reply <= fresh;  // held until the last reply byte of the read.
        end
    end

    // reads start on the address byte itself, writes use the latched address.
    assign rd_addr_byte = (state == ST_RD_SFR_ADDR) || (state == ST_RD_WORD_ADDR);
    assign acc_addr     = rd_addr_byte ? {addr_hi, rx_byte} : {addr_hi, addr_lo};

    assign sfr_addr   = acc_addr;
    assign sfr_wdata  = {data0, rx_byte};
    assign sfr_rd     = byte_in && (state == ST_RD_SFR_ADDR);
    assign sfr_wr     = byte_in && (state == ST_WR_SFR_B1);

    assign word_addr  = acc_addr;
    assign word_wdata = {data0, data1, data2, rx_byte};
    assign word_rd    = byte_in && (state == ST_RD_WORD_ADDR);
    assign word_wr    = byte_in && (state == ST_WR_WORD_B3);

    // the load right after the address byte takes the data straight from the target.
    assign fresh     = (state == ST_RD_SFR_B0) ? word_t'(sfr_rdata) : word_rdata;
    assign cur_reply = rd_pend ? fresh : reply;

    always_comb begin
        case (state)
            ST_RD_SFR_B0:  tx_byte = cur_reply[15:8];
            ST_RD_SFR_B1:  tx_byte = cur_reply[7:0];
            ST_RD_WORD_B0: tx_byte = cur_reply[31:24];
            ST_RD_WORD_B1: tx_byte = cur_reply[23:16];
            ST_RD_WORD_B2: tx_byte = cur_reply[15:8];
            ST_RD_WORD_B3: tx_byte = cur_reply[7:0];
            default:       tx_byte = 8'h00;
        endcase
    end

endmodule

// ==== logic/sfr_bank.sv ====
//////////////////////////////
// SFR bank with 64 registers of 16 bits.
// Register 0 is a read-only identity value.
// Addresses past the bank read 0 and drop writes.
//////////////////////////////
`timescale 1ns/1ps
`include "spi_bridge_cfg.svh"

module sfr_bank
    import spi_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  addr_t     addr,
    input  sfr_data_t wdata,
    input  logic      wr,
    input  logic      rd,
    output sfr_data_t rdata
);

    localparam int IDX_W = $clog2(`SB_SFR_COUNT);

    sfr_data_t        regs [1:`SB_SFR_COUNT-1];
    logic [IDX_W-1:0] idx;
    logic             in_range;

    assign idx      = addr[IDX_W-1:0];
    assign in_range = (addr < addr_t'(`SB_SFR_COUNT));

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `SB_SFR_COUNT; i++) begin
                regs[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (wr && in_range && idx != '0) begin
                regs[idx] <= wdata;
            end
            if (rd) begin
                rdata <= !in_range   ? '0 :
                         (idx == '0) ? `SB_SFR_ID :
                                       regs[idx];
            end
        end
    end

endmodule

// ==== logic/word_ram.sv ====
//////////////////////////////
// Word memory of 4096 x 32 bits.
// Contents are undefined until written.
//////////////////////////////
`timescale 1ns/1ps
`include "spi_bridge_cfg.svh"

module word_ram
    import spi_bridge_pkg::*;
(
    input  logic  clk,
    input  addr_t addr,
    input  word_t wdata,
    input  logic  wr,
    input  logic  rd,
    output word_t rdata
);

    localparam int DEPTH = 1 << `SB_ADDR_W;

    word_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= wdata;
        end
    end

    // data is valid one clk after rd and holds until the next rd.
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== logic/spi_bridge_top.sv ====
//////////////////////////////
// SPI to register bridge top level.
// SPI mode 0 only, SCLK half period of 4 clk or more.
//////////////////////////////
`timescale 1ns/1ps

module spi_bridge_top
    import spi_bridge_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    byte_t     rx_byte;
    logic      rx_valid;
    logic      rx_first;
    logic      frame_end;
    logic      tx_load;
    byte_t     tx_byte;
    addr_t     sfr_addr;
    sfr_data_t sfr_wdata;
    logic      sfr_wr;
    logic      sfr_rd;
    sfr_data_t sfr_rdata;
    addr_t     word_addr;
    word_t     word_wdata;
    logic      word_wr;
    logic      word_rd;
    word_t     word_rdata;

    spi_byte_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .rx_first  (rx_first),
        .frame_end (frame_end),
        .tx_load   (tx_load),
        .tx_byte   (tx_byte)
    );

    spi_cmd_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .rx_first   (rx_first),
        .frame_end  (frame_end),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .sfr_addr   (sfr_addr),
        .sfr_wdata  (sfr_wdata),
        .sfr_wr     (sfr_wr),
        .sfr_rd     (sfr_rd),
        .sfr_rdata  (sfr_rdata),
        .word_addr  (word_addr),
        .word_wdata (word_wdata),
        .word_wr    (word_wr),
        .word_rd    (word_rd),
        .word_rdata (word_rdata)
    );

    sfr_bank u_sfr (
        .clk   (clk),
        .rst   (rst),
        .addr  (sfr_addr),
        .wdata (sfr_wdata),
        .wr    (sfr_wr),
        .rd    (sfr_rd),
        .rdata (sfr_rdata)
    );

    word_ram u_ram (
        .clk   (clk),
        .addr  (word_addr),
        .wdata (word_wdata),
        .wr    (word_wr),
        .rd    (word_rd),
        .rdata (word_rdata)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
//////////////////////////////
// 4 ns clock, reset high for 5 cycles.
//////////////////////////////
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;  // released 1 ns after the edge like every other input.
    end

endmodule

// ==== tests/spi_bridge_tb.sv ====
//////////////////////////////
// SPI master model and checker for the register bridge.
// SCLK half period is 4 clk, inputs move 1 ns after clk rises.
// Word reads only target words written earlier in the run.
//////////////////////////////
`timescale 1ns/1ps
`include "spi_bridge_cfg.svh"

module spi_bridge_tb
    import spi_bridge_pkg::*;
();

    localparam int SCLK_HALF = 4;

    logic clk;
    logic rst;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;

    sfr_data_t   sfr_model [0:`SB_SFR_COUNT-1];
    word_t       word_model [0:(1 << `SB_ADDR_W)-1];
    bit          word_written [0:(1 << `SB_ADDR_W)-1];
    addr_t       word_addrs [$];
    byte_t       tx_buf [0:7];
    byte_t       rx_buf [0:7];
    byte_t       exp_q [$];
    byte_t       got_q [$];
    int          where_q [$];
    int          frame_no = 0;
    int          n_pushed = 0;
    int          n_checked = 0;
    logic [31:0] rng = 32'd67025;

    tb_clock_gen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    spi_bridge_top dut0 (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .cs_n (cs_n),
        .mosi (mosi),
        .miso (miso)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int data_len(input opcode_t op);
        if (op == `SB_OP_RD_SFR || op == `SB_OP_WR_SFR) begin
            return 2;
        end
        if (op == `SB_OP_RD_WORD || op == `SB_OP_WR_WORD) begin
            return 4;
        end
        return 0;
    endfunction

    // reply byte idx of a frame as the bridge should send it, from the model.
    function automatic byte_t expected_reply(input opcode_t op, input addr_t addr, input int idx);
        word_t value;
        int    n_data;
        value  = '0;
        n_data = 0;
        if (op == `SB_OP_RD_SFR) begin
            n_data = 2;
            if (addr == 0) begin
                value = word_t'(`SB_SFR_ID);
            end else if (addr < `SB_SFR_COUNT) begin
                value = word_t'(sfr_model[addr[5:0]]);
            end
        end else if (op == `SB_OP_RD_WORD) begin
            n_data = 4;
            value  = word_model[addr];
        end
        if (idx < 2 || idx >= 2 + n_data) begin
            return 8'h00;
        end
        return byte_t'(value >> (8 * (n_data - 1 - (idx - 2))));
    endfunction

    task automatic update_model(input opcode_t op, input addr_t addr, input int n_bytes);
        if (op == `SB_OP_WR_SFR && n_bytes >= 4 && addr != 0 && addr < `SB_SFR_COUNT) begin
            sfr_model[addr[5:0]] = {tx_buf[2], tx_buf[3]};
        end
        if (op == `SB_OP_WR_WORD && n_bytes >= 6) begin
            word_model[addr] = {tx_buf[2], tx_buf[3], tx_buf[4], tx_buf[5]};
            if (!word_written[addr]) begin
                word_addrs.push_back(addr);
            end
            word_written[addr] = 1'b1;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic half_period();
        repeat (SCLK_HALF) @(posedge clk);
        #1;
    endtask

    // mode 0 byte, MSB first. miso is read just before the rising edge.
    task automatic xfer_byte(input byte_t tx, output byte_t rx);
        rx = 8'h00;
        for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            half_period();
            rx[b] = miso;
            sclk  = 1'b1;
            half_period();
            sclk  = 1'b0;
        end
    endtask

    task automatic run_frame(input int n_bytes);
        cs_n = 1'b0;
        half_period();
        for (int i = 0; i < n_bytes; i++) begin
            xfer_byte(tx_buf[i], rx_buf[i]);
        end
        half_period();
        cs_n = 1'b1;
        half_period();
        half_period();
    endtask

    task automatic do_frame(input opcode_t op, input addr_t addr, input word_t data,
                            input int n_bytes);
        int n_data;
        n_data    = data_len(op);
        tx_buf[0] = {op, addr[`SB_ADDR_W-1:8]};
        tx_buf[1] = addr[7:0];
        for (int i = 2; i < 8; i++) begin
            tx_buf[i] = byte_t'(next_rand());
        end
        for (int i = 0; i < n_data; i++) begin
            tx_buf[2 + i] = byte_t'(data >> (8 * (n_data - 1 - i)));
        end
        run_frame(n_bytes);
        for (int i = 0; i < n_bytes; i++) begin
            exp_q.push_back(expected_reply(op, addr, i));
            got_q.push_back(rx_buf[i]);
            where_q.push_back(frame_no * 8 + i);
            n_pushed++;
        end
        update_model(op, addr, n_bytes);
        frame_no++;
    endtask

    function automatic addr_t pick_word_addr();
        return word_addrs[next_rand() % word_addrs.size()];
    endfunction

    initial begin
        byte_t exp_b;
        byte_t got_b;
        int    w;
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                exp_b = exp_q.pop_front();
                got_b = got_q.pop_front();
                w     = where_q.pop_front();
                n_checked++;
                assert (got_b === exp_b)
                else begin
                    $display("[FAIL] miso frame %0d byte %0d: expected 0x%02h, got 0x%02h",
                             w / 8, w % 8, exp_b, got_b);
                    abort_run("reply byte does not match the reference model");
                end
            end
        end
    end

    initial begin
        opcode_t op;
        addr_t   addr;
        word_t   data;
        int      n;
        int      pick;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        for (int i = 0; i < `SB_SFR_COUNT; i++) begin
            sfr_model[i] = '0;
        end
        for (int i = 0; i < 50 && rst !== 1'b0; i++) begin
            @(posedge clk);
        end
        if (rst !== 1'b0) begin
            abort_run("reset was not released in time");
        end
        #1;
        half_period();

        // identity register ignores writes.
        do_frame(`SB_OP_RD_SFR, addr_t'(0), '0, 4);
        do_frame(`SB_OP_WR_SFR, addr_t'(0), 32'h0000_1234, 4);
        do_frame(`SB_OP_RD_SFR, addr_t'(0), '0, 4);

        for (int i = 0; i < 20; i++) begin
            addr = (i < 15) ? addr_t'(next_rand() % 64) : addr_t'(64 + next_rand() % 4032);
            do_frame(`SB_OP_WR_SFR, addr, next_rand(), 4);
            do_frame(`SB_OP_RD_SFR, addr, '0, 4);
        end

        for (int i = 0; i < 20; i++) begin
            addr = addr_t'(next_rand());
            do_frame(`SB_OP_WR_WORD, addr, next_rand(), 6);
            do_frame(`SB_OP_RD_WORD, addr, '0, 6);
        end

        // unknown opcodes aimed at live locations must leave them intact.
        for (int i = 0; i < 5; i++) begin
            op   = opcode_t'(4 + next_rand() % 12);
            addr = pick_word_addr();
            do_frame(op, addr, next_rand(), 6);
            do_frame(`SB_OP_RD_WORD, addr, '0, 6);
            addr = addr_t'(1 + next_rand() % 63);
            do_frame(op, addr, next_rand(), 6);
            do_frame(`SB_OP_RD_SFR, addr, '0, 4);
        end

        // surplus bytes after a write, then writes cut short.
        addr = addr_t'(1 + next_rand() % 63);
        do_frame(`SB_OP_WR_SFR, addr, next_rand(), 6);
        do_frame(`SB_OP_RD_SFR, addr, '0, 4);
        addr = pick_word_addr();
        do_frame(`SB_OP_WR_WORD, addr, next_rand(), 7);
        do_frame(`SB_OP_RD_WORD, addr, '0, 6);
        addr = addr_t'(1 + next_rand() % 63);
        do_frame(`SB_OP_WR_SFR, addr, next_rand(), 3);
        do_frame(`SB_OP_RD_SFR, addr, '0, 4);
        addr = pick_word_addr();
        do_frame(`SB_OP_WR_WORD, addr, next_rand(), 5);
        do_frame(`SB_OP_RD_WORD, addr, '0, 6);

        for (int f = 0; f < 200; f++) begin
            pick = int'(next_rand() % 5);
            addr = addr_t'(next_rand());
            data = next_rand();
            if (pick == 0 || pick == 1) begin
                op = (pick == 0) ? `SB_OP_RD_SFR : `SB_OP_WR_SFR;
                if (next_rand() % 4 != 0) begin
                    addr = addr_t'(addr[5:0]);  // mostly inside the bank.
                end
            end else if (pick == 2) begin
                op   = `SB_OP_RD_WORD;
                addr = pick_word_addr();
            end else if (pick == 3) begin
                op = `SB_OP_WR_WORD;
            end else begin
                op = opcode_t'(4 + next_rand() % 12);
            end
            n = 2 + data_len(op);
            if (pick == 4) begin
                n = 2 + int'(next_rand() % 5);
            end else if (next_rand() % 5 == 0) begin
                n = n + 1;
            end else if ((pick == 1 || pick == 3) && next_rand() % 5 == 0) begin
                n = n - 1;
            end
            do_frame(op, addr, data, n);
        end

        for (int i = 0; i < 20 && got_q.size() > 0; i++) begin
            @(posedge clk);
        end
        if (got_q.size() == 0 && n_checked == n_pushed) begin
            $display("checked %0d reply bytes in %0d frames", n_checked, frame_no);
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("not all reply bytes were compared before the end of the run");
        end
    end

endmodule

// ==== flist.f ====
+incdir+include
logic/spi_bridge_pkg.sv
logic/spi_byte_slave.sv
logic/spi_cmd_ctrl.sv
logic/sfr_bank.sv
logic/word_ram.sv
logic/spi_bridge_top.sv
tests/tb_clock_gen.sv
tests/spi_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the SPI bridge testbench with Verilator and runs it into sim.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module spi_bridge_tb -o spi_bridge_sim \
    && ./obj_dir/spi_bridge_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
